// ==== neptuno_params.svh ====
`ifndef NEPTUNO_PARAMS_SVH
`define NEPTUNO_PARAMS_SVH

// ------------------------------------------------------------------------
// Joystick shift-register chain
// ------------------------------------------------------------------------

// clk_sys cycles per half period of the joystick shift clock
`define NEPTUNO_JOY_CLK_DIV 4

// Bits per scan of the two chained 8-bit registers
`define NEPTUNO_JOY_CHAIN_BITS 16

// ------------------------------------------------------------------------
// I2S audio path
// ------------------------------------------------------------------------

// clk_sys cycles per half period of the bit clock
`define NEPTUNO_I2S_BCLK_DIV 2

// Width of one audio sample
`define NEPTUNO_SND_W 16

// Sample buffer entries and credits handed out after reset
`define NEPTUNO_SND_DEPTH 4

`endif

// ==== neptuno_pkg.sv ====
`include "neptuno_params.svh"

package neptuno_pkg;

    // Button positions inside a six-bit joystick vector
    typedef enum logic [2:0] {
        RIGHT = 3'd0,
        LEFT  = 3'd1,
        DOWN  = 3'd2,
        UP    = 3'd3,
        FIRE1 = 3'd4,
        FIRE2 = 3'd5
    } joy_bit_e;

    // Joystick reader sequencing
    typedef enum logic [1:0] {
        LOAD,
        SHIFT,
        UPDATE
    } scan_state_e;

    // Credit handout first, then normal streaming
    typedef enum logic {
        CREDIT_INIT,
        RUN
    } i2s_state_e;

    // One signed audio word
    typedef logic signed [`NEPTUNO_SND_W-1:0] snd_sample_t;

endpackage

// ==== joy_serial_reader.sv ====
`include "neptuno_params.svh"

module joy_serial_reader
    import neptuno_pkg::*;
(
    input  logic       clk_sys,
    input  logic       arst_n_i,
    input  logic       joy_data_i,
    output logic       joy_clk_o,
    output logic       joy_load_o,
    output logic [5:0] joy1_o,
    output logic [5:0] joy2_o
);

    localparam int HALF   = `NEPTUNO_JOY_CLK_DIV;
    localparam int NBITS  = `NEPTUNO_JOY_CHAIN_BITS;
    localparam int DIV_W  = $clog2(2 * HALF);
    localparam int BCNT_W = $clog2(NBITS) + 1;

    scan_state_e       state;
    logic [DIV_W-1:0]  div_cnt;
    logic [BCNT_W-1:0] bit_cnt;
    logic [NBITS-1:0]  shift_q;
    logic              clk_q;
    logic              load_q;
    logic              half_end;
    logic              period_end;

    // Last cycle of the low half and of the whole shift-clock period
    assign half_end   = (div_cnt == DIV_W'(HALF - 1));
    assign period_end = (div_cnt == DIV_W'(2 * HALF - 1));

    assign joy_clk_o  = clk_q;
    assign joy_load_o = load_q;

    // Stream order is UP, DOWN, LEFT, RIGHT, FIRE1, FIRE2 and pins are active low
    function automatic logic [5:0] decode_joy(input logic [5:0] raw);
        logic [5:0] joy;
        joy        = '0;
        joy[UP]    = ~raw[0];
        joy[DOWN]  = ~raw[1];
        joy[LEFT]  = ~raw[2];
        joy[RIGHT] = ~raw[3];
        joy[FIRE1] = ~raw[4];
        joy[FIRE2] = ~raw[5];
        return joy;
    endfunction

    // ------------------------------------------------------------------------
    // Scan sequencer
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_sys or negedge arst_n_i) begin
        if (!arst_n_i) begin
            // Start in UPDATE so the first load pulse gets its full length
            state   <= UPDATE;
            div_cnt <= '0;
            bit_cnt <= '0;
            clk_q   <= 1'b0;
            load_q  <= 1'b1;
            joy1_o  <= '0;
            joy2_o  <= '0;
        end else begin
            case (state)
                LOAD: begin
                    div_cnt <= div_cnt + 1'b1;
                    if (period_end) begin
                        div_cnt <= '0;
                        load_q  <= 1'b1;
                        state   <= SHIFT;
                    end
                end

                SHIFT: begin
                    div_cnt <= div_cnt + 1'b1;
                    if (half_end) begin
                        clk_q <= 1'b1;
                    end
                    if (period_end) begin
                        div_cnt <= '0;
                        clk_q   <= 1'b0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == BCNT_W'(NBITS - 1)) begin
                            state <= UPDATE;
                        end
                    end
                end

                UPDATE: begin
                    // Only a completed scan is published
                    if (bit_cnt == BCNT_W'(NBITS)) begin
                        joy1_o <= decode_joy(shift_q[5:0]);
                        joy2_o <= decode_joy(shift_q[13:8]);
                    end
                    bit_cnt <= '0;
                    div_cnt <= '0;
                    load_q  <= 1'b0;
                    state   <= LOAD;
                end

                default: begin
                    state <= UPDATE;
                end
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Serial data capture
    // ------------------------------------------------------------------------

    // Sampled just before the rising shift clock so the first bit ends up in bit 0
    always_ff @(posedge clk_sys) begin
        if (state == SHIFT && half_end) begin
            shift_q <= {joy_data_i, shift_q[NBITS-1:1]};
        end
    end

endmodule

// ==== i2s_tx.sv ====
`include "neptuno_params.svh"

module i2s_tx
    import neptuno_pkg::*;
(
    input  logic        clk_sys,
    input  logic        arst_n_i,
    input  logic        snd_valid_i,
    input  snd_sample_t snd_left_i,
    input  snd_sample_t snd_right_i,
    output logic        snd_credit_o,
    output logic        i2s_bclk_o,
    output logic        i2s_lrclk_o,
    output logic        i2s_data_o
);

    localparam int DEPTH   = `NEPTUNO_SND_DEPTH;
    localparam int PTR_W   = $clog2(DEPTH);
    localparam int BDIV    = `NEPTUNO_I2S_BCLK_DIV;
    localparam int BDIV_W  = (BDIV > 1) ? $clog2(BDIV) : 1;
    localparam int FRAME_W = 2 * `NEPTUNO_SND_W;
    localparam int POS_W   = $clog2(FRAME_W);

    i2s_state_e         state;
    logic [PTR_W-1:0]   init_cnt;
    logic               credit_q;

    snd_sample_t        mem_l [DEPTH];
    snd_sample_t        mem_r [DEPTH];
    logic [PTR_W:0]     wr_ptr;
    logic [PTR_W:0]     rd_ptr;
    logic               full;
    logic               empty;
    logic               push;
    logic               pop;

    logic [BDIV_W-1:0]  bdiv_cnt;
    logic               bclk_q;
    logic               bclk_tick;
    logic               fall_edge;
    logic [POS_W-1:0]   pos;
    logic [POS_W-1:0]   pos_next;
    logic               frame_start;
    logic               lrclk_q;
    logic               data_q;
    logic [FRAME_W-1:0] shreg;
    logic [FRAME_W-1:0] next_frame;

    assign snd_credit_o = credit_q;
    assign i2s_bclk_o   = bclk_q;
    assign i2s_lrclk_o  = lrclk_q;
    assign i2s_data_o   = data_q;

    // ------------------------------------------------------------------------
    // Credit handout
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_sys or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state    <= CREDIT_INIT;
            init_cnt <= '0;
            credit_q <= 1'b0;
        end else begin
            case (state)
                CREDIT_INIT: begin
                    // One credit per buffer entry on consecutive cycles
                    credit_q <= 1'b1;
                    init_cnt <= init_cnt + 1'b1;
                    if (init_cnt == PTR_W'(DEPTH - 1)) begin
                        state <= RUN;
                    end
                end
                RUN: begin
                    // Every pair taken by the serializer frees one entry
                    credit_q <= pop;
                end
                default: begin
                    state <= CREDIT_INIT;
                end
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Sample buffer
    // ------------------------------------------------------------------------
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                   (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

    // A valid on a full buffer is a source error and gets dropped
    assign push = snd_valid_i && !full;
    assign pop  = frame_start && !empty;

    // Silence when nothing is queued
    assign next_frame = empty ? '0 :
                        {mem_l[rd_ptr[PTR_W-1:0]], mem_r[rd_ptr[PTR_W-1:0]]};

    always_ff @(posedge clk_sys) begin
        if (push) begin
            mem_l[wr_ptr[PTR_W-1:0]] <= snd_left_i;
            mem_r[wr_ptr[PTR_W-1:0]] <= snd_right_i;
        end
    end

    always_ff @(posedge clk_sys or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // I2S serializer
    // ------------------------------------------------------------------------
    assign bclk_tick   = (state == RUN) && (bdiv_cnt == BDIV_W'(BDIV - 1));
    assign fall_edge   = bclk_tick && bclk_q;
    assign pos_next    = pos + 1'b1;

    // Slot 0 is the LRCLK falling edge and the left MSB follows one bit later
    assign frame_start = fall_edge && (pos_next == '0);

    always_ff @(posedge clk_sys or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bdiv_cnt <= '0;
            bclk_q   <= 1'b0;
            pos      <= '0;
            lrclk_q  <= 1'b0;
            data_q   <= 1'b0;
            shreg    <= '0;
        end else if (state == RUN) begin
            if (bclk_tick) begin
                bdiv_cnt <= '0;
                bclk_q   <= ~bclk_q;
            end else begin
                bdiv_cnt <= bdiv_cnt + 1'b1;
            end

            // Data and LRCLK move together on the falling bit clock
            if (fall_edge) begin
                pos     <= pos_next;
                lrclk_q <= pos_next[POS_W-1];
                data_q  <= shreg[FRAME_W-1];
                if (frame_start) begin
                    shreg <= next_frame;
                end else begin
                    shreg <= {shreg[FRAME_W-2:0], 1'b0};
                end
            end
        end
    end

endmodule

// ==== neptuno_top.sv ====
module neptuno_top
    import neptuno_pkg::*;
(
    input  logic        clk_sys,
    input  logic        arst_n_i,

    // Joystick shift-register chain
    input  logic        joy_data_i,
    output logic        joy_clk_o,
    output logic        joy_load_o,
    output logic [5:0]  joy1_o,
    output logic [5:0]  joy2_o,

    // Audio samples under credit flow control
    input  logic        snd_valid_i,
    input  snd_sample_t snd_left_i,
    input  snd_sample_t snd_right_i,
    output logic        snd_credit_o,

    // External DAC
    output logic        i2s_bclk_o,
    output logic        i2s_lrclk_o,
    output logic        i2s_data_o
);

    // ------------------------------------------------------------------------
    // Joystick reader
    // ------------------------------------------------------------------------
    joy_serial_reader u_joy (
        .clk_sys    ( clk_sys    ),
        .arst_n_i   ( arst_n_i   ),
        .joy_data_i ( joy_data_i ),
        .joy_clk_o  ( joy_clk_o  ),
        .joy_load_o ( joy_load_o ),
        .joy1_o     ( joy1_o     ),
        .joy2_o     ( joy2_o     )
    );

    // ------------------------------------------------------------------------
    // Audio transmitter
    // ------------------------------------------------------------------------

    // Left and right always arrive as separate words
    i2s_tx u_i2s (
        .clk_sys      ( clk_sys      ),
        .arst_n_i     ( arst_n_i     ),
        .snd_valid_i  ( snd_valid_i  ),
        .snd_left_i   ( snd_left_i   ),
        .snd_right_i  ( snd_right_i  ),
        .snd_credit_o ( snd_credit_o ),
        .i2s_bclk_o   ( i2s_bclk_o   ),
        .i2s_lrclk_o  ( i2s_lrclk_o  ),
        .i2s_data_o   ( i2s_data_o   )
    );

endmodule

// ==== tb_board_models.sv ====
// ------------------------------------------------------------------------
// Two chained 8-bit parallel-in shift registers
// ------------------------------------------------------------------------
module tb_joy_chain_model (
    input  logic        clk_i,
    input  logic        load_n_i,
    input  logic        shift_clk_i,
    input  logic [15:0] pattern_i,
    output logic        data_o
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [15:0] sr = 16'hffff;
    logic        shift_clk_q = 1'b0;

    assign data_o = sr[0];

    // Parallel load while load is low and shift on the rising shift clock otherwise
    always @(posedge clk_i) begin
        shift_clk_q <= shift_clk_i;
        if (!load_n_i) begin
            sr <= pattern_i;
        end else if (shift_clk_i && !shift_clk_q) begin
            sr <= {1'b1, sr[15:1]};
        end
    end

endmodule

// ------------------------------------------------------------------------
// I2S receiver that rebuilds left/right pairs
// ------------------------------------------------------------------------
module tb_i2s_capture (
    input  logic        bclk_i,
    input  logic        lrclk_i,
    input  logic        data_i,
    output logic [15:0] left_o,
    output logic [15:0] right_o,
    output int          pair_cnt_o,
    output int          len_err_o
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [15:0] word = '0;
    int          nbits = 0;
    logic        prev_lr = 1'b0;
    logic        armed = 1'b0;

    initial begin
        left_o     = '0;
        right_o    = '0;
        pair_cnt_o = 0;
        len_err_o  = 0;
    end

    // The bit on an LRCLK change is still the LSB of the previous word
    always @(posedge bclk_i) begin
        word  = {word[14:0], data_i};
        nbits = nbits + 1;
        if (lrclk_i != prev_lr) begin
            if (armed) begin
                if (nbits != 16) begin
                    $display("I2S word of %0d bits instead of 16 at %0t", nbits, $time);
                    len_err_o = len_err_o + 1;
                end
                if (prev_lr) begin
                    right_o    = word;
                    pair_cnt_o = pair_cnt_o + 1;
                end else begin
                    left_o = word;
                end
            end else if (prev_lr) begin
                // Start on the first complete frame
                armed = 1'b1;
            end
            nbits = 0;
            word  = '0;
        end
        prev_lr = lrclk_i;
    end

endmodule

// ==== tb_neptuno_top.sv ====
`include "neptuno_params.svh"

module tb_neptuno_top
    import neptuno_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NJOY = 6;
    localparam int NSND = 6;

    logic        clk_sys;
    logic        arst_n_i;
    logic        joy_data, joy_clk, joy_load;
    logic [5:0]  joy1, joy2;
    logic        snd_valid;
    snd_sample_t snd_left, snd_right;
    logic        snd_credit;
    logic        i2s_bclk, i2s_lrclk, i2s_data;
    logic [15:0] pattern;
    logic [15:0] cap_left, cap_right;
    int          pair_cnt, len_err;

    logic [11:0] joy_table [NJOY];
    logic [31:0] snd_table [NSND];
    logic [31:0] got_q [$];
    logic [31:0] lcg_state;
    int          errors, checks, tests, credits_rx, sent, last_pair_cnt;
    logic        audio_started;

    neptuno_top dut_i (
        .clk_sys(clk_sys), .arst_n_i(arst_n_i),
        .joy_data_i(joy_data), .joy_clk_o(joy_clk), .joy_load_o(joy_load),
        .joy1_o(joy1), .joy2_o(joy2),
        .snd_valid_i(snd_valid), .snd_left_i(snd_left), .snd_right_i(snd_right),
        .snd_credit_o(snd_credit),
        .i2s_bclk_o(i2s_bclk), .i2s_lrclk_o(i2s_lrclk), .i2s_data_o(i2s_data)
    );

    tb_joy_chain_model chain_i (
        .clk_i(clk_sys), .load_n_i(joy_load), .shift_clk_i(joy_clk),
        .pattern_i(pattern), .data_o(joy_data)
    );

    tb_i2s_capture cap_i (
        .bclk_i(i2s_bclk), .lrclk_i(i2s_lrclk), .data_i(i2s_data),
        .left_o(cap_left), .right_o(cap_right), .pair_cnt_o(pair_cnt), .len_err_o(len_err)
    );

    initial begin
        clk_sys = 1'b0;
        forever #2 clk_sys = ~clk_sys;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Stream order UP, DOWN, LEFT, RIGHT, FIRE1, FIRE2 with active-low pins
    function automatic logic [5:0] pin_bits(input logic [5:0] joy);
        return ~{joy[FIRE2], joy[FIRE1], joy[RIGHT], joy[LEFT], joy[DOWN], joy[UP]};
    endfunction

    task automatic check_value(input string msg, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %0h expected %0h", $time, msg, got, exp);
            errors++;
        end
    endtask

    // Advance one cycle and sample credits and captured pairs on the falling edge
    task automatic tick();
        @(negedge clk_sys);
        if (snd_credit) credits_rx++;
        if (pair_cnt != last_pair_cnt) begin
            last_pair_cnt = pair_cnt;
            if (cap_left != 0 || cap_right != 0) audio_started = 1'b1;
            if (audio_started) got_q.push_back({cap_left, cap_right});
        end
    endtask

    task automatic wait_load_fall();
        int t;
        t = 0;
        while (!(joy_load === 1'b1) && t < 500) begin
            tick();
            t++;
        end
        while (joy_load === 1'b1 && t < 500) begin
            tick();
            t++;
        end
        if (t >= 500) begin
            $display("Timeout: joystick load pulse did not come");
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests++;
        $display("Test %0d %s: %s", tests, name, (errors == err_before) ? "ok" : "failed");
    endtask

    initial begin
        int e0;
        int t;
        errors = 0;
        checks = 0;
        tests = 0;
        credits_rx = 0;
        sent = 0;
        last_pair_cnt = 0;
        audio_started = 1'b0;
        lcg_state = 32'd14;
        arst_n_i = 1'b0;
        snd_valid = 1'b0;
        snd_left = '0;
        snd_right = '0;
        pattern = 16'hffff;
        joy_table = '{12'h000, 12'hfff, 12'h555, 12'h2aa, 12'h801, 12'h0c3};
        for (int i = 0; i < NSND; i++) begin
            snd_table[i] = lcg_next();
            if (snd_table[i][31:16] == 0) snd_table[i][31:16] = 16'h1;
            if (snd_table[i][15:0] == 0) snd_table[i][15:0] = 16'h1;
        end

        // Reset values and initial credits
        e0 = errors;
        repeat (4) tick();
        check_value("joy_load_o in reset", joy_load, 1);
        check_value("joy_clk_o in reset", joy_clk, 0);
        check_value("joy1_o in reset", joy1, 0);
        check_value("joy2_o in reset", joy2, 0);
        check_value("snd_credit_o in reset", snd_credit, 0);
        check_value("i2s_bclk_o in reset", i2s_bclk, 0);
        check_value("i2s_lrclk_o in reset", i2s_lrclk, 0);
        check_value("i2s_data_o in reset", i2s_data, 0);
        arst_n_i = 1'b1;
        repeat (12) tick();
        check_value("initial credits", credits_rx, `NEPTUNO_SND_DEPTH);
        report_test("reset", e0);

        // Joystick table with two full scans per entry
        e0 = errors;
        for (int i = 0; i < NJOY; i++) begin
            pattern = {2'b11, pin_bits(joy_table[i][5:0]), 2'b11, pin_bits(joy_table[i][11:6])};
            repeat (3) wait_load_fall();
            check_value($sformatf("joy1_o entry %0d", i), joy1, joy_table[i][11:6]);
            check_value($sformatf("joy2_o entry %0d", i), joy2, joy_table[i][5:0]);
        end
        report_test("joystick", e0);

        // Audio samples sent one per held credit
        e0 = errors;
        for (int i = 0; i < NSND; i++) begin
            t = 0;
            while (credits_rx - sent <= 0 && t < 1000) begin
                tick();
                t++;
            end
            if (t >= 1000) begin
                $display("Timeout: no credit for audio sample %0d", i);
                errors++;
            end
            snd_valid = 1'b1;
            snd_left  = snd_table[i][31:16];
            snd_right = snd_table[i][15:0];
            sent++;
            tick();
            snd_valid = 1'b0;
        end
        t = 0;
        while (got_q.size() < NSND + 2 && t < 5000) begin
            tick();
            t++;
        end
        if (t >= 5000) begin
            $display("Timeout: I2S frames did not arrive");
            errors++;
        end
        for (int i = 0; i < NSND && i < got_q.size(); i++) begin
            check_value($sformatf("I2S pair %0d", i), got_q[i], snd_table[i]);
        end
        report_test("audio order", e0);

        // Credit return and drained buffer
        e0 = errors;
        t = 0;
        while (got_q.size() < NSND + 4 && t < 1000) begin
            tick();
            t++;
        end
        if (t >= 1000) begin
            $display("Timeout: silent I2S frames did not arrive");
            errors++;
        end
        check_value("total credits", credits_rx, `NEPTUNO_SND_DEPTH + NSND);
        for (int i = NSND; i < got_q.size(); i++) begin
            check_value($sformatf("silent frame %0d", i), got_q[i], 0);
        end
        check_value("I2S word length errors", len_err, 0);
        report_test("drain", e0);

        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+.
neptuno_pkg.sv
joy_serial_reader.sv
i2s_tx.sv
neptuno_top.sv
tb_board_models.sv
tb_neptuno_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wall -Wno-fatal \
    --top-module tb_neptuno_top \
    -f files.f \
    -o sim_neptuno

out=$(./obj_dir/sim_neptuno)
echo "$out"

if echo "$out" | grep -q "Result: PASSED"; then
    exit 0
else
    exit 1
fi
